//--- build.f
+incdir+.
obi_integrity_pkg.sv
obi_achk_gen.sv
obi_outstanding_fifo.sv
obi_resp_check.sv
obi_integrity_channel.sv
integrity_alert_ctrl.sv
obi_integrity_top.sv
tb_obi_integrity.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the OBI integrity testbench with Verilator
verilator --binary --timing -j 0 --timescale 1ns/100ps \
  --top-module tb_obi_integrity -f build.f -o sim_obi_integrity \
  && ./obj_dir/sim_obi_integrity | tee /dev/stderr | grep -qx "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb_obi_integrity_ref.svh
// OBI integrity reference model
// Expected achk, rchk and response integrity error for one bus

`ifndef TB_OBI_INTEGRITY_REF_SVH
`define TB_OBI_INTEGRITY_REF_SVH

function automatic logic [12:0] achk_of(
  input logic [31:0] wdata,
  input logic        dbg,
  input logic [3:0]  be,
  input logic        we,
  input logic [2:0]  prot,
  input logic [1:0]  memtype,
  input logic [31:0] addr
);
  // atop and mid are always zero, so their parity bits are zero
  return {^wdata[31:24], ^wdata[23:16], ^wdata[15:8], ^wdata[7:0],
          ~^dbg, 1'b0, 1'b0, ~^{be, we}, ~^{prot, memtype},
          ^addr[31:24], ^addr[23:16], ^addr[15:8], ^addr[7:0]};
endfunction

function automatic logic [4:0] rchk_of(input logic err, input logic [31:0] rdata);
  return {err, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
endfunction

function automatic logic response_flagged(
  input logic        enabled,
  input logic        had_integrity,
  input logic        was_store,
  input logic        gnt_fault,
  input logic        rvalidpar,
  input logic        err,
  input logic [31:0] rdata,
  input logic [4:0]  rchk
);
  logic [4:0] diff;
  logic       bad;
  diff = rchk ^ rchk_of(err, rdata);
  bad  = was_store ? diff[4] : (diff != 5'b0);
  return (enabled && had_integrity && bad) || gnt_fault || rvalidpar;
endfunction

`endif

//--- tb_obi_integrity.sv
// OBI integrity unit testbench
// Random fetch, load and store traffic with rchk and parity faults,
// checked every cycle against a reference model of the unit

module tb_obi_integrity;
  timeunit 1ns;
  timeprecision 100ps;

  import obi_integrity_pkg::*;

  `include "tb_obi_integrity_ref.svh"

  localparam int DEPTH = 4;

  logic      clk_i;
  logic      arst_n;
  logic      instr_req;
  bus_addr_t instr_addr;
  logic      instr_dbg;
  prot_t     instr_prot;
  memtype_t  instr_memtype;
  logic      instr_integrity;
  logic      instr_gnt;
  logic      instr_gntpar;
  logic      instr_rvalid;
  logic      instr_rvalidpar;
  bus_data_t instr_rdata;
  logic      instr_err;
  rchk_t     instr_rchk;
  logic      instr_reqpar;
  achk_t     instr_achk;
  logic      instr_integrity_err;
  logic      data_req;
  bus_addr_t data_addr;
  bus_data_t data_wdata;
  be_t       data_be;
  logic      data_we;
  logic      data_dbg;
  prot_t     data_prot;
  memtype_t  data_memtype;
  logic      data_integrity;
  logic      data_gnt;
  logic      data_gntpar;
  logic      data_rvalid;
  logic      data_rvalidpar;
  bus_data_t data_rdata;
  logic      data_err;
  rchk_t     data_rchk;
  logic      data_reqpar;
  achk_t     data_achk;
  logic      data_integrity_err;
  logic      cfg_we;
  logic      cfg_integrity_en;
  logic      integrity_enabled;
  logic      alert_major;
  logic      rchk_err_instr;
  logic      rchk_err_data;

  // Requests in flight as seen by the memory side
  int          inflight_i = 0;
  int          inflight_d = 0;
  int unsigned drv_errors = 0;

  // Reference model state kept by the comparison process
  logic [2:0]  q_instr[$];
  logic [2:0]  q_data[$];
  logic [2:0]  head_i;
  logic [2:0]  head_d;
  rchk_t       diff_d;
  logic        exp_ierr_i;
  logic        exp_ierr_d;
  logic        chk_i;
  logic        chk_d;
  logic        par_i;
  logic        par_d;
  logic        exp_en;
  logic        exp_alert;
  logic        exp_rerr_i;
  logic        exp_rerr_d;
  int unsigned errors = 0;
  int unsigned n_checks = 0;
  int unsigned chk_hits = 0;
  int unsigned gnt_resp_hits = 0;
  int unsigned store_masked = 0;

  obi_integrity_top #(
    .MAX_OUTSTANDING (DEPTH)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    errors++;
  endtask

  // One cycle of memory-side activity for one bus
  task automatic draw_bus_cycle(input int unsigned flip_pct, input int unsigned par_pct,
                                input bit new_req, inout int inflight,
                                output logic req, output logic gnt, output logic gntpar,
                                output logic rvalid, output logic rvalidpar,
                                output logic err, output bus_data_t rdata,
                                output rchk_t rchk);
    rchk_t flip;
    rvalid = (inflight > 0) && ($urandom_range(1) == 1);
    req    = new_req && ($urandom_range(3) != 0);
    // Never grant beyond the record depth
    gnt    = ($urandom_range(1) == 1) && (inflight < DEPTH);
    if (req && gnt) inflight++;
    if (rvalid) inflight--;
    gntpar    = !gnt;
    rvalidpar = !rvalid;
    if ($urandom_range(99) < par_pct) gntpar = !gntpar;
    if ($urandom_range(99) < par_pct) rvalidpar = !rvalidpar;
    err   = ($urandom_range(7) == 0);
    rdata = $urandom();
    flip  = '0;
    if ($urandom_range(99) < flip_pct) flip = 5'(1 << $urandom_range(4));
    rchk  = rchk_of(err, rdata) ^ flip;
  endtask

  task automatic drive_cycle(input int unsigned flip_pct, input int unsigned par_pct,
                             input bit new_req);
    logic      rq;
    logic      gn;
    logic      gp;
    logic      rv;
    logic      rp;
    logic      er;
    bus_data_t rd;
    rchk_t     ck;
    @(posedge clk_i);
    draw_bus_cycle(flip_pct, par_pct, new_req, inflight_i, rq, gn, gp, rv, rp, er, rd, ck);
    instr_req       <= rq;
    instr_gnt       <= gn;
    instr_gntpar    <= gp;
    instr_rvalid    <= rv;
    instr_rvalidpar <= rp;
    instr_err       <= er;
    instr_rdata     <= rd;
    instr_rchk      <= ck;
    draw_bus_cycle(flip_pct, par_pct, new_req, inflight_d, rq, gn, gp, rv, rp, er, rd, ck);
    data_req        <= rq;
    data_gnt        <= gn;
    data_gntpar     <= gp;
    data_rvalid     <= rv;
    data_rvalidpar  <= rp;
    data_err        <= er;
    data_rdata      <= rd;
    data_rchk       <= ck;
    instr_addr      <= $urandom();
    instr_dbg       <= 1'($urandom());
    instr_prot      <= 3'($urandom());
    instr_memtype   <= 2'($urandom());
    instr_integrity <= ($urandom_range(7) != 0);
    data_addr       <= $urandom();
    data_wdata      <= $urandom();
    data_be         <= 4'($urandom());
    data_we         <= 1'($urandom());
    data_dbg        <= 1'($urandom());
    data_prot       <= 3'($urandom());
    data_memtype    <= 2'($urandom());
    data_integrity  <= ($urandom_range(7) != 0);
  endtask

  // Strobe lands on the edge that drive_cycle has just waited for
  task automatic write_enable(input logic en);
    cfg_we           <= 1'b1;
    cfg_integrity_en <= en;
    drive_cycle(0, 0, 1'b1);
    cfg_we           <= 1'b0;
  endtask

  task automatic drain_responses(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while ((inflight_i != 0 || inflight_d != 0) && n < max_cycles) begin
      drive_cycle(0, 0, 1'b0);
      n++;
    end
    if (inflight_i != 0 || inflight_d != 0) begin
      $display("Timeout: responses still outstanding after %0d cycles", max_cycles);
      drv_errors++;
    end
  endtask

  // Compare every output with the reference model at the falling edge
  always @(negedge clk_i) begin
    if (!arst_n) begin
      q_instr.delete();
      q_data.delete();
      exp_en     = 1'b1;
      exp_alert  = 1'b0;
      exp_rerr_i = 1'b0;
      exp_rerr_d = 1'b0;
    end else begin
      head_i = (q_instr.size() != 0) ? q_instr[0] : 3'b000;
      head_d = (q_data.size() != 0) ? q_data[0] : 3'b000;
      exp_ierr_i = instr_rvalid && response_flagged(exp_en, head_i[1], head_i[2], head_i[0],
                   instr_rvalidpar, instr_err, instr_rdata, instr_rchk);
      exp_ierr_d = data_rvalid && response_flagged(exp_en, head_d[1], head_d[2], head_d[0],
                   data_rvalidpar, data_err, data_rdata, data_rchk);
      chk_i = instr_rvalid && response_flagged(exp_en, head_i[1], head_i[2], 1'b0, 1'b0,
              instr_err, instr_rdata, instr_rchk);
      chk_d = data_rvalid && response_flagged(exp_en, head_d[1], head_d[2], 1'b0, 1'b0,
              data_err, data_rdata, data_rchk);
      par_i = (instr_gntpar == instr_gnt) || (instr_rvalidpar == instr_rvalid);
      par_d = (data_gntpar == data_gnt) || (data_rvalidpar == data_rvalid);

      if (instr_reqpar !== !instr_req)
        report_mismatch("instr_reqpar", 32'(instr_reqpar), 32'(!instr_req));
      if (data_reqpar !== !data_req)
        report_mismatch("data_reqpar", 32'(data_reqpar), 32'(!data_req));
      if (instr_achk !== achk_of(32'h0, instr_dbg, 4'hf, 1'b0, instr_prot, instr_memtype,
                                 instr_addr))
        report_mismatch("instr_achk", 32'(instr_achk), 32'(achk_of(32'h0, instr_dbg, 4'hf,
                        1'b0, instr_prot, instr_memtype, instr_addr)));
      if (data_achk !== achk_of(data_wdata, data_dbg, data_be, data_we, data_prot,
                                data_memtype, data_addr))
        report_mismatch("data_achk", 32'(data_achk), 32'(achk_of(data_wdata, data_dbg,
                        data_be, data_we, data_prot, data_memtype, data_addr)));
      if (instr_integrity_err !== exp_ierr_i)
        report_mismatch("instr_integrity_err", 32'(instr_integrity_err), 32'(exp_ierr_i));
      if (data_integrity_err !== exp_ierr_d)
        report_mismatch("data_integrity_err", 32'(data_integrity_err), 32'(exp_ierr_d));
      if (integrity_enabled !== exp_en)
        report_mismatch("integrity_enabled", 32'(integrity_enabled), 32'(exp_en));
      if (alert_major !== exp_alert)
        report_mismatch("alert_major", 32'(alert_major), 32'(exp_alert));
      if (rchk_err_instr !== exp_rerr_i)
        report_mismatch("rchk_err_instr", 32'(rchk_err_instr), 32'(exp_rerr_i));
      if (rchk_err_data !== exp_rerr_d)
        report_mismatch("rchk_err_data", 32'(rchk_err_data), 32'(exp_rerr_d));
      n_checks += 10;

      // Store responses whose data bits were corrupted must stay quiet
      diff_d = data_rchk ^ rchk_of(data_err, data_rdata);
      if (data_rvalid && head_d[2] && head_d[1] && exp_en && diff_d[3:0] != 4'h0 &&
          !diff_d[4]) store_masked++;
      if (chk_i || chk_d) chk_hits++;
      // Responses to requests whose grant had a parity fault
      if ((instr_rvalid && head_i[0]) || (data_rvalid && head_d[0])) gnt_resp_hits++;

      // State for the next cycle
      exp_alert  = chk_i || chk_d || par_i || par_d;
      exp_rerr_i = chk_i;
      exp_rerr_d = chk_d;
      if (cfg_we) exp_en = cfg_integrity_en;
      if (instr_rvalid && q_instr.size() != 0) void'(q_instr.pop_front());
      if (data_rvalid && q_data.size() != 0) void'(q_data.pop_front());
      if (instr_req && instr_gnt)
        q_instr.push_back({1'b0, instr_integrity, instr_gntpar == instr_gnt});
      if (data_req && data_gnt)
        q_data.push_back({data_we, data_integrity, data_gntpar == data_gnt});
    end
  end

  initial begin
    void'($urandom(99334));
    arst_n           <= 1'b0;
    instr_req        <= 1'b0;
    instr_addr       <= '0;
    instr_dbg        <= 1'b0;
    instr_prot       <= '0;
    instr_memtype    <= '0;
    instr_integrity  <= 1'b1;
    instr_gnt        <= 1'b0;
    instr_gntpar     <= 1'b1;
    instr_rvalid     <= 1'b0;
    instr_rvalidpar  <= 1'b1;
    instr_rdata      <= '0;
    instr_err        <= 1'b0;
    instr_rchk       <= '0;
    data_req         <= 1'b0;
    data_addr        <= '0;
    data_wdata       <= '0;
    data_be          <= '0;
    data_we          <= 1'b0;
    data_dbg         <= 1'b0;
    data_prot        <= '0;
    data_memtype     <= '0;
    data_integrity   <= 1'b1;
    data_gnt         <= 1'b0;
    data_gntpar      <= 1'b1;
    data_rvalid      <= 1'b0;
    data_rvalidpar   <= 1'b1;
    data_rdata       <= '0;
    data_err         <= 1'b0;
    data_rchk        <= '0;
    cfg_we           <= 1'b0;
    cfg_integrity_en <= 1'b1;
    repeat (3) @(posedge clk_i);
    arst_n <= 1'b1;

    // Clean traffic and then corrupted rchk with integrity on
    repeat (300) drive_cycle(0, 0, 1'b1);
    repeat (400) drive_cycle(25, 0, 1'b1);
    drain_responses(200);
    // Checking off while the parity lines are still watched
    write_enable(1'b0);
    repeat (300) drive_cycle(30, 5, 1'b1);
    drain_responses(200);
    write_enable(1'b1);
    repeat (400) drive_cycle(15, 5, 1'b1);
    drain_responses(200);
    repeat (2) drive_cycle(0, 0, 1'b0);

    if (chk_hits == 0 || gnt_resp_hits == 0 || store_masked == 0) begin
      $display("Stimulus did not reach every checksum and grant fault case");
      drv_errors++;
    end
    $display("Checks: %0d, compare errors: %0d, other errors: %0d", n_checks, errors,
             drv_errors);
    if (errors == 0 && drv_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_obi_integrity

//--- obi_integrity_top.sv
// OBI bus integrity unit
// Instruction and data channels with shared enable and major alert

module obi_integrity_top #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                         clk_i,
  input  logic                         arst_n,
  // Instruction bus
  input  logic                         instr_req,
  input  obi_integrity_pkg::bus_addr_t instr_addr,
  input  logic                         instr_dbg,
  input  obi_integrity_pkg::prot_t     instr_prot,
  input  obi_integrity_pkg::memtype_t  instr_memtype,
  input  logic                         instr_integrity,
  input  logic                         instr_gnt,
  input  logic                         instr_gntpar,
  input  logic                         instr_rvalid,
  input  logic                         instr_rvalidpar,
  input  obi_integrity_pkg::bus_data_t instr_rdata,
  input  logic                         instr_err,
  input  obi_integrity_pkg::rchk_t     instr_rchk,
  output logic                         instr_reqpar,
  output obi_integrity_pkg::achk_t     instr_achk,
  output logic                         instr_integrity_err,
  // Data bus
  input  logic                         data_req,
  input  obi_integrity_pkg::bus_addr_t data_addr,
  input  obi_integrity_pkg::bus_data_t data_wdata,
  input  obi_integrity_pkg::be_t       data_be,
  input  logic                         data_we,
  input  logic                         data_dbg,
  input  obi_integrity_pkg::prot_t     data_prot,
  input  obi_integrity_pkg::memtype_t  data_memtype,
  input  logic                         data_integrity,
  input  logic                         data_gnt,
  input  logic                         data_gntpar,
  input  logic                         data_rvalid,
  input  logic                         data_rvalidpar,
  input  obi_integrity_pkg::bus_data_t data_rdata,
  input  logic                         data_err,
  input  obi_integrity_pkg::rchk_t     data_rchk,
  output logic                         data_reqpar,
  output obi_integrity_pkg::achk_t     data_achk,
  output logic                         data_integrity_err,
  // Configuration and alerts
  input  logic                         cfg_we,
  input  logic                         cfg_integrity_en,
  output logic                         integrity_enabled,
  output logic                         alert_major,
  output logic                         rchk_err_instr,
  output logic                         rchk_err_data
);
  import obi_integrity_pkg::*;

  logic instr_chk_fault;
  logic instr_parity_fault;
  logic data_chk_fault;
  logic data_parity_fault;

  // Fetch side has no write fields, tie them to the fetch defaults
  obi_integrity_channel #(
    .BUS             (BUS_INSTR),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_instr_channel (
    .clk_i             (clk_i),
    .arst_n            (arst_n),
    .integrity_enabled (integrity_enabled),
    .req               (instr_req),
    .addr              (instr_addr),
    .wdata             ('0),
    .be                (INSTR_BE),
    .we                (1'b0),
    .dbg               (instr_dbg),
    .prot              (instr_prot),
    .memtype           (instr_memtype),
    .integrity         (instr_integrity),
    .gnt               (instr_gnt),
    .gntpar            (instr_gntpar),
    .rvalid            (instr_rvalid),
    .rvalidpar         (instr_rvalidpar),
    .rdata             (instr_rdata),
    .err               (instr_err),
    .rchk              (instr_rchk),
    .reqpar            (instr_reqpar),
    .achk              (instr_achk),
    .integrity_err     (instr_integrity_err),
    .chk_fault         (instr_chk_fault),
    .parity_fault      (instr_parity_fault)
  );

  obi_integrity_channel #(
    .BUS             (BUS_DATA),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_data_channel (
    .clk_i             (clk_i),
    .arst_n            (arst_n),
    .integrity_enabled (integrity_enabled),
    .req               (data_req),
    .addr              (data_addr),
    .wdata             (data_wdata),
    .be                (data_be),
    .we                (data_we),
    .dbg               (data_dbg),
    .prot              (data_prot),
    .memtype           (data_memtype),
    .integrity         (data_integrity),
    .gnt               (data_gnt),
    .gntpar            (data_gntpar),
    .rvalid            (data_rvalid),
    .rvalidpar         (data_rvalidpar),
    .rdata             (data_rdata),
    .err               (data_err),
    .rchk              (data_rchk),
    .reqpar            (data_reqpar),
    .achk              (data_achk),
    .integrity_err     (data_integrity_err),
    .chk_fault         (data_chk_fault),
    .parity_fault      (data_parity_fault)
  );

  integrity_alert_ctrl u_alert_ctrl (
    .clk_i              (clk_i),
    .arst_n             (arst_n),
    .cfg_we             (cfg_we),
    .cfg_integrity_en   (cfg_integrity_en),
    .instr_parity_fault (instr_parity_fault),
    .data_parity_fault  (data_parity_fault),
    .instr_chk_fault    (instr_chk_fault),
    .data_chk_fault     (data_chk_fault),
    .integrity_enabled  (integrity_enabled),
    .alert_major        (alert_major),
    .rchk_err_instr     (rchk_err_instr),
    .rchk_err_data      (rchk_err_data)
  );

endmodule : obi_integrity_top

//--- integrity_alert_ctrl.sv
// Integrity alert control
// Holds the integrity enable and registers the major alert and the
// per-bus checksum error flags

module integrity_alert_ctrl (
  input  logic clk_i,
  input  logic arst_n,
  input  logic cfg_we,
  input  logic cfg_integrity_en,
  input  logic instr_parity_fault,
  input  logic data_parity_fault,
  input  logic instr_chk_fault,
  input  logic data_chk_fault,
  output logic integrity_enabled,
  output logic alert_major,
  output logic rchk_err_instr,
  output logic rchk_err_data
);

  logic any_fault;

  assign any_fault = instr_parity_fault || data_parity_fault ||
                     instr_chk_fault || data_chk_fault;

  // Checking is on out of reset
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      integrity_enabled <= 1'b1;
    end else if (cfg_we) begin
      integrity_enabled <= cfg_integrity_en;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      alert_major    <= 1'b0;
      rchk_err_instr <= 1'b0;
      rchk_err_data  <= 1'b0;
    end else begin
      alert_major    <= any_fault;
      rchk_err_instr <= instr_chk_fault;
      rchk_err_data  <= data_chk_fault;
    end
  end

endmodule : integrity_alert_ctrl

//--- obi_integrity_channel.sv
// OBI integrity channel
// Request checksum and parity, outstanding record and response check
// for one bus

module obi_integrity_channel #(
  parameter obi_integrity_pkg::obi_bus_e BUS             = obi_integrity_pkg::BUS_DATA,
  parameter int unsigned                 MAX_OUTSTANDING = 2
) (
  input  logic                         clk_i,
  input  logic                         arst_n,
  input  logic                         integrity_enabled,
  input  logic                         req,
  input  obi_integrity_pkg::bus_addr_t addr,
  input  obi_integrity_pkg::bus_data_t wdata,
  input  obi_integrity_pkg::be_t       be,
  input  logic                         we,
  input  logic                         dbg,
  input  obi_integrity_pkg::prot_t     prot,
  input  obi_integrity_pkg::memtype_t  memtype,
  input  logic                         integrity,
  input  logic                         gnt,
  input  logic                         gntpar,
  input  logic                         rvalid,
  input  logic                         rvalidpar,
  input  obi_integrity_pkg::bus_data_t rdata,
  input  logic                         err,
  input  obi_integrity_pkg::rchk_t     rchk,
  output logic                         reqpar,
  output obi_integrity_pkg::achk_t     achk,
  output logic                         integrity_err,
  output logic                         chk_fault,
  output logic                         parity_fault
);
  import obi_integrity_pkg::*;

  logic accept;
  logic gnt_fault;
  logic is_store;
  logic head_store;
  logic head_integrity;
  logic head_gnt_fault;

  assign reqpar    = ~req;
  assign accept    = req && gnt;
  assign gnt_fault = (gntpar == gnt);
  assign is_store  = (BUS == BUS_DATA) && we;

  // Parity lines are watched every cycle, independent of the enable
  assign parity_fault = gnt_fault || (rvalidpar == rvalid);

  obi_achk_gen #(
    .BUS (BUS)
  ) u_achk_gen (
    .addr    (addr),
    .wdata   (wdata),
    .be      (be),
    .we      (we),
    .dbg     (dbg),
    .prot    (prot),
    .memtype (memtype),
    .achk    (achk)
  );

  obi_outstanding_fifo #(
    .DEPTH (MAX_OUTSTANDING)
  ) u_outstanding (
    .clk_i          (clk_i),
    .arst_n         (arst_n),
    .push           (accept),
    .pop            (rvalid),
    .push_store     (is_store),
    .push_integrity (integrity),
    .push_gnt_fault (gnt_fault),
    .head_store     (head_store),
    .head_integrity (head_integrity),
    .head_gnt_fault (head_gnt_fault)
  );

  obi_resp_check u_resp_check (
    .integrity_enabled (integrity_enabled),
    .rvalid            (rvalid),
    .rvalidpar         (rvalidpar),
    .rdata             (rdata),
    .err               (err),
    .rchk              (rchk),
    .head_store        (head_store),
    .head_integrity    (head_integrity),
    .head_gnt_fault    (head_gnt_fault),
    .chk_fault         (chk_fault),
    .integrity_err     (integrity_err)
  );

endmodule : obi_integrity_channel

//--- obi_resp_check.sv
// OBI response checker
// Recomputes rchk and flags the integrity error for the response at hand

module obi_resp_check (
  input  logic                         integrity_enabled,
  input  logic                         rvalid,
  input  logic                         rvalidpar,
  input  obi_integrity_pkg::bus_data_t rdata,
  input  logic                         err,
  input  obi_integrity_pkg::rchk_t     rchk,
  input  logic                         head_store,
  input  logic                         head_integrity,
  input  logic                         head_gnt_fault,
  output logic                         chk_fault,
  output logic                         integrity_err
);
  import obi_integrity_pkg::*;

  rchk_t rchk_exp;
  rchk_t rchk_diff;
  logic  mismatch;
  logic  rvalid_par_fault;

  // exokay is never set, so the top bit reduces to err
  assign rchk_exp = {
    err,
    ^rdata[31:24],
    ^rdata[23:16],
    ^rdata[15:8],
    ^rdata[7:0]
  };

  assign rchk_diff = rchk ^ rchk_exp;

  // Store responses carry no data, only the error bit is covered
  assign mismatch = head_store ? rchk_diff[RCHK_ERR_BIT] : (rchk_diff != '0);

  assign chk_fault = rvalid && head_integrity && integrity_enabled && mismatch;

  assign rvalid_par_fault = (rvalidpar == rvalid);

  assign integrity_err = rvalid && (chk_fault || head_gnt_fault || rvalid_par_fault);

endmodule : obi_resp_check

//--- obi_outstanding_fifo.sv
// Outstanding request record
// Keeps store, integrity and grant parity flags for each accepted request
// until its response arrives, in request order

module obi_outstanding_fifo #(
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic arst_n,
  input  logic push,
  input  logic pop,
  input  logic push_store,
  input  logic push_integrity,
  input  logic push_gnt_fault,
  output logic head_store,
  output logic head_integrity,
  output logic head_gnt_fault
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Entry layout is {store, integrity, gnt_fault}
  logic [2:0]       mem [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign do_pop = pop && (count != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr] <= {push_store, push_integrity, push_gnt_fault};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (do_pop) begin
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!push && do_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Nothing outstanding reads as a clean entry
  assign head_store     = (count != '0) && mem[rptr][2];
  assign head_integrity = (count != '0) && mem[rptr][1];
  assign head_gnt_fault = (count != '0) && mem[rptr][0];

endmodule : obi_outstanding_fifo

//--- obi_achk_gen.sv
// OBI request checksum generator
// Builds the 13-bit achk for one bus from the request fields

module obi_achk_gen #(
  parameter obi_integrity_pkg::obi_bus_e BUS = obi_integrity_pkg::BUS_DATA
) (
  input  obi_integrity_pkg::bus_addr_t addr,
  input  obi_integrity_pkg::bus_data_t wdata,
  input  obi_integrity_pkg::be_t       be,
  input  logic                         we,
  input  logic                         dbg,
  input  obi_integrity_pkg::prot_t     prot,
  input  obi_integrity_pkg::memtype_t  memtype,
  output obi_integrity_pkg::achk_t     achk
);
  import obi_integrity_pkg::*;

  bus_data_t wdata_eff;
  be_t       be_eff;
  logic      we_eff;

  // Fetches carry no write data and are always full-word reads
  assign wdata_eff = (BUS == BUS_INSTR) ? '0 : wdata;
  assign be_eff    = (BUS == BUS_INSTR) ? INSTR_BE : be;
  assign we_eff    = (BUS == BUS_INSTR) ? 1'b0 : we;

  assign achk = {
    ^wdata_eff[31:24],
    ^wdata_eff[23:16],
    ^wdata_eff[15:8],
    ^wdata_eff[7:0],
    ~^dbg,
    ^ATOP_ASSUMED,
    ^MID_ASSUMED,
    ~^{be_eff, we_eff},
    ~^{prot, memtype},
    ^addr[31:24],
    ^addr[23:16],
    ^addr[15:8],
    ^addr[7:0]
  };

endmodule : obi_achk_gen

//--- obi_integrity_pkg.sv
// OBI bus integrity package
// Shared field types, checksum widths and the constant values assumed
// for request fields the core never drives

package obi_integrity_pkg;

  // Bus field types
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  be_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  memtype_t;

  // Checksum types
  typedef logic [12:0] achk_t;
  typedef logic [4:0]  rchk_t;

  // The core never issues atomics and has a single manager id
  parameter logic [5:0] ATOP_ASSUMED = 6'b00_0000;
  parameter logic [7:0] MID_ASSUMED  = 8'h00;

  // Fetches always read a full word
  parameter be_t INSTR_BE = 4'b1111;

  // rchk bit covering err and exokay, the only bit checked on stores
  parameter int unsigned RCHK_ERR_BIT = 4;

  // Channel kind
  typedef enum logic {
    BUS_INSTR,
    BUS_DATA
  } obi_bus_e;

endpackage : obi_integrity_pkg
